//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = mips_core_tb
FILELIST = mips_core.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- include/mips_cfg.svh
// -----------------------------------------------
// Core sizing. The regfile assumes 32 registers.
// Data memory depth must be a power of two.
// -----------------------------------------------
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Architectural register count
`define MIPS_NUM_REGS 32

// Data memory depth in words, addresses wrap at this size
`define MIPS_DMEM_WORDS 64

`define MIPS_RESET_PC 32'h0000_0000  // First PC after reset

`endif

//--- logic/cpu_ctl.sv
// -----------------------------------------------
// Pure combinational decode. Unknown op or funct
// leaves every flag low, which acts as a no-op.
// -----------------------------------------------
`timescale 1ns/1ns

module cpu_ctl (
  input  mips_pkg::instr_u i_instr,
  input  logic             i_equal,
  output mips_pkg::ctl_s   o_ctl
);
  import mips_pkg::*;

  localparam logic [5:0] OP_RTYPE = 6'b000000;
  localparam logic [5:0] OP_J     = 6'b000010;
  localparam logic [5:0] OP_JAL   = 6'b000011;
  localparam logic [5:0] OP_BEQ   = 6'b000100;
  localparam logic [5:0] OP_BNE   = 6'b000101;
  localparam logic [5:0] OP_ADDI  = 6'b001000;
  localparam logic [5:0] OP_ADDIU = 6'b001001;
  localparam logic [5:0] OP_SLTI  = 6'b001010;
  localparam logic [5:0] OP_SLTIU = 6'b001011;
  localparam logic [5:0] OP_ANDI  = 6'b001100;
  localparam logic [5:0] OP_ORI   = 6'b001101;
  localparam logic [5:0] OP_XORI  = 6'b001110;
  localparam logic [5:0] OP_LUI   = 6'b001111;
  localparam logic [5:0] OP_LW    = 6'b100011;
  localparam logic [5:0] OP_SW    = 6'b101011;

  localparam logic [5:0] FN_SLL  = 6'b000000;
  localparam logic [5:0] FN_SRL  = 6'b000010;
  localparam logic [5:0] FN_SRA  = 6'b000011;
  localparam logic [5:0] FN_JR   = 6'b001000;
  localparam logic [5:0] FN_ADD  = 6'b100000;
  localparam logic [5:0] FN_ADDU = 6'b100001;
  localparam logic [5:0] FN_SUB  = 6'b100010;
  localparam logic [5:0] FN_AND  = 6'b100100;
  localparam logic [5:0] FN_OR   = 6'b100101;
  localparam logic [5:0] FN_XOR  = 6'b100110;
  localparam logic [5:0] FN_SLT  = 6'b101010;
  localparam logic [5:0] FN_SLTU = 6'b101011;

  logic r_hit;  // Supported R-type ALU funct

  always_comb begin
    o_ctl        = '0;
    o_ctl.alu_op = ADD;
    r_hit        = 1'b0;
    case (i_instr.i_fmt.op)
      OP_RTYPE: begin
        r_hit = 1'b1;
        case (i_instr.r_fmt.funct)
          FN_ADD, FN_ADDU: o_ctl.alu_op = ADD;  // No overflow trap
          FN_SUB:  o_ctl.alu_op = SUB;
          FN_AND:  o_ctl.alu_op = AND;
          FN_OR:   o_ctl.alu_op = OR;
          FN_XOR:  o_ctl.alu_op = XOR;
          FN_SLT:  o_ctl.alu_op = SLT;
          FN_SLTU: o_ctl.alu_op = SLTU;
          FN_SLL:  begin o_ctl.alu_op = SLL; o_ctl.shamt_src = 1'b1; end
          FN_SRL:  begin o_ctl.alu_op = SRL; o_ctl.shamt_src = 1'b1; end
          FN_SRA:  begin o_ctl.alu_op = SRA; o_ctl.shamt_src = 1'b1; end
          FN_JR: begin
            o_ctl.jr = 1'b1;
            r_hit    = 1'b0;
          end
          default: r_hit = 1'b0;
        endcase
        o_ctl.wreg    = r_hit;
        o_ctl.rd_dest = r_hit;
      end
      OP_J:   o_ctl.j = 1'b1;
      OP_JAL: begin
        o_ctl.jal  = 1'b1;
        o_ctl.wreg = 1'b1;  // Link into r31
      end
      OP_BEQ, OP_BNE: begin
        o_ctl.sext   = 1'b1;
        o_ctl.alu_op = SUB;
        // Equality comes from the regfile read ports
        o_ctl.take_branch = (i_instr.i_fmt.op == OP_BEQ) ? i_equal : ~i_equal;
      end
      OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LW: begin
        o_ctl.wreg    = 1'b1;
        o_ctl.imm_src = 1'b1;
        o_ctl.sext    = 1'b1;
        o_ctl.lw      = (i_instr.i_fmt.op == OP_LW);
        if (i_instr.i_fmt.op == OP_SLTI) o_ctl.alu_op = SLT;
        if (i_instr.i_fmt.op == OP_SLTIU) o_ctl.alu_op = SLTU;
      end
      OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
        o_ctl.wreg    = 1'b1;
        o_ctl.imm_src = 1'b1;  // Zero-extended
        case (i_instr.i_fmt.op)
          OP_ANDI: o_ctl.alu_op = AND;
          OP_ORI:  o_ctl.alu_op = OR;
          OP_XORI: o_ctl.alu_op = XOR;
          default: o_ctl.alu_op = LUI;
        endcase
      end
      OP_SW: begin
        o_ctl.wmem    = 1'b1;
        o_ctl.imm_src = 1'b1;
        o_ctl.sext    = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- logic/mips_alu.sv
// -----------------------------------------------
// 32-bit ALU, no overflow detection.
// Shifts act on operand B.
// -----------------------------------------------
`timescale 1ns/1ns

module mips_alu (
  input  mips_pkg::alu_op_e i_op,
  input  logic [31:0]       i_a,
  input  logic [31:0]       i_b,
  input  logic [4:0]        i_shamt,
  output logic [31:0]       o_y
);
  import mips_pkg::*;

  logic lt_signed;
  logic lt_unsigned;

  assign lt_signed   = $signed(i_a) < $signed(i_b);
  assign lt_unsigned = i_a < i_b;

  always_comb begin
    case (i_op)
      ADD:  o_y = i_a + i_b;
      SUB:  o_y = i_a - i_b;
      AND:  o_y = i_a & i_b;
      OR:   o_y = i_a | i_b;
      XOR:  o_y = i_a ^ i_b;
      SLT:  o_y = {31'b0, lt_signed};
      SLTU: o_y = {31'b0, lt_unsigned};
      SLL:  o_y = i_b << i_shamt;
      SRL:  o_y = i_b >> i_shamt;
      SRA:  o_y = $signed(i_b) >>> i_shamt;  // Keeps sign bit
      LUI:  o_y = {i_b[15:0], 16'h0000};
      default: o_y = i_a + i_b;
    endcase
  end

endmodule

//--- logic/mips_core.sv
// -----------------------------------------------
// Single-issue core, one instruction in flight.
// No fetch, no exceptions, no delay slots.
// -----------------------------------------------
`timescale 1ns/1ns
`include "mips_cfg.svh"

module mips_core (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic [31:0]       i_instr,
  input  logic              i_instr_valid,
  output logic              o_instr_ready,
  output mips_pkg::result_s o_res,
  output logic              o_res_valid,
  input  logic              i_res_ready
);
  import mips_pkg::*;

  localparam int DMEM_AW = $clog2(`MIPS_DMEM_WORDS);

  instr_u             instr;
  ctl_s               ctl;
  result_s            res_d;
  result_s            res_q;
  logic               res_valid_q;
  logic               xfer_in;
  logic               equal;
  logic [31:0]        pc_q;
  logic [31:0]        pc_plus4;
  logic [31:0]        next_pc;
  logic [31:0]        rs_data;
  logic [31:0]        rt_data;
  logic [31:0]        imm_ext;
  logic [31:0]        alu_b;
  logic [31:0]        alu_y;
  logic [31:0]        mem_rdata;
  logic [4:0]         shamt;
  logic [4:0]         wr_addr;
  logic [31:0]        wr_data;
  logic [DMEM_AW-1:0] mem_idx;

  assign instr         = i_instr;
  assign o_instr_ready = ~res_valid_q | i_res_ready;  // Empty or draining now
  assign xfer_in       = i_instr_valid & o_instr_ready;

  mips_regfile regfile_i (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_rs_addr (instr.i_fmt.rs),
    .i_rt_addr (instr.i_fmt.rt),
    .o_rs_data (rs_data),
    .o_rt_data (rt_data),
    .i_we      (xfer_in & ctl.wreg),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data)
  );

  assign equal = (rs_data == rt_data);

  cpu_ctl ctl_i (
    .i_instr (instr),
    .i_equal (equal),
    .o_ctl   (ctl)
  );

  assign imm_ext = ctl.sext ? {{16{instr.i_fmt.imm[15]}}, instr.i_fmt.imm}
                            : {16'h0000, instr.i_fmt.imm};
  assign alu_b   = ctl.imm_src ? imm_ext : rt_data;
  assign shamt   = ctl.shamt_src ? instr.r_fmt.shamt : rs_data[4:0];

  mips_alu alu_i (
    .i_op    (ctl.alu_op),
    .i_a     (rs_data),
    .i_b     (alu_b),
    .i_shamt (shamt),
    .o_y     (alu_y)
  );

  assign mem_idx = alu_y[DMEM_AW+1:2];  // Wraps at memory depth

  mips_data_mem dmem_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_addr  (mem_idx),
    .i_we    (xfer_in & ctl.wmem),
    .i_wdata (rt_data),
    .o_rdata (mem_rdata)
  );

  assign pc_plus4 = pc_q + 32'd4;

  always_comb begin
    if (ctl.jr) begin
      next_pc = rs_data;
    end else if (ctl.j || ctl.jal) begin
      next_pc = {pc_plus4[31:28], instr.j_fmt.target, 2'b00};
    end else if (ctl.take_branch) begin
      next_pc = pc_plus4 + {imm_ext[29:0], 2'b00};
    end else begin
      next_pc = pc_plus4;  // Also the no-op path
    end
  end

  // Write-back select
  assign wr_addr = ctl.jal ? 5'd31 : (ctl.rd_dest ? instr.r_fmt.rd : instr.i_fmt.rt);
  assign wr_data = ctl.jal ? pc_plus4 : (ctl.lw ? mem_rdata : alu_y);

  always_comb begin
    res_d          = '0;
    res_d.pc       = pc_q;
    res_d.next_pc  = next_pc;
    res_d.wreg     = ctl.wreg;
    res_d.wmem     = ctl.wmem;
    if (ctl.wreg) begin
      res_d.wr_addr = wr_addr;
      res_d.wr_data = wr_data;
    end
    if (ctl.wmem) begin
      res_d.mem_addr = alu_y;
      res_d.mem_data = rt_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc_q        <= `MIPS_RESET_PC;
      res_valid_q <= 1'b0;
    end else if (xfer_in) begin
      pc_q        <= next_pc;
      res_valid_q <= 1'b1;
    end else if (i_res_ready) begin
      res_valid_q <= 1'b0;
    end
  end

  // Payload only loads on accept, so it holds under back-pressure
  always_ff @(posedge i_clk) begin
    if (xfer_in) begin
      res_q <= res_d;
    end
  end

  assign o_res       = res_q;
  assign o_res_valid = res_valid_q;

endmodule

//--- logic/mips_data_mem.sv
// -----------------------------------------------
// Word-indexed RAM, async read, clocked write.
// -----------------------------------------------
`timescale 1ns/1ns
`include "mips_cfg.svh"

module mips_data_mem (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  input  logic [$clog2(`MIPS_DMEM_WORDS)-1:0] i_addr,   // Word index
  input  logic                                i_we,
  input  logic [31:0]                         i_wdata,
  output logic [31:0]                         o_rdata
);

  logic [31:0] mem_q [`MIPS_DMEM_WORDS];

  assign o_rdata = mem_q[i_addr];

  // Cleared so loads before any store are defined
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `MIPS_DMEM_WORDS; i++) begin
        mem_q[i] <= 32'h0;
      end
    end else if (i_we) begin
      mem_q[i_addr] <= i_wdata;
    end
  end

endmodule

//--- logic/mips_pkg.sv
// -----------------------------------------------
// Shared types. Result fields for an unused write
// port are reported as zero.
// -----------------------------------------------
package mips_pkg;

  // R-type layout
  typedef struct packed {
    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fmt_s;

  // I-type layout
  typedef struct packed {
    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fmt_s;

  // J-type layout
  typedef struct packed {
    logic [5:0]  op;
    logic [25:0] target;
  } j_fmt_s;

  // One instruction word, three decodings
  typedef union packed {
    r_fmt_s r_fmt;
    i_fmt_s i_fmt;
    j_fmt_s j_fmt;
  } instr_u;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,   // Signed compare
    SLTU,  // Unsigned compare
    SLL,
    SRL,
    SRA,
    LUI    // Immediate into upper half
  } alu_op_e;

  // Decoder output
  typedef struct packed {
    logic    jr;
    logic    j;
    logic    jal;
    logic    lw;
    logic    wreg;
    logic    wmem;
    logic    rd_dest;      // Dest is rd, else rt
    logic    sext;         // Sign-extend imm
    logic    shamt_src;    // Shift by shamt field
    logic    imm_src;      // Operand B is imm
    logic    take_branch;
    alu_op_e alu_op;
  } ctl_s;

  // One record per executed instruction
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic        wreg;
    logic [4:0]  wr_addr;
    logic [31:0] wr_data;
    logic        wmem;
    logic [31:0] mem_addr;  // Byte address, before word indexing
    logic [31:0] mem_data;
  } result_s;

endpackage

//--- logic/mips_regfile.sv
// -----------------------------------------------
// 2R1W register file. Reads are combinational,
// r0 always reads zero.
// -----------------------------------------------
`timescale 1ns/1ns
`include "mips_cfg.svh"

module mips_regfile (
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic [4:0]  i_rs_addr,
  input  logic [4:0]  i_rt_addr,
  output logic [31:0] o_rs_data,
  output logic [31:0] o_rt_data,
  input  logic        i_we,
  input  logic [4:0]  i_wr_addr,
  input  logic [31:0] i_wr_data
);

  logic [31:0] regs_q [`MIPS_NUM_REGS];

  // r0 forced on the read side as well
  assign o_rs_data = (i_rs_addr == 5'd0) ? 32'h0 : regs_q[i_rs_addr];
  assign o_rt_data = (i_rt_addr == 5'd0) ? 32'h0 : regs_q[i_rt_addr];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
        regs_q[i] <= 32'h0;
      end
    end else if (i_we && (i_wr_addr != 5'd0)) begin
      regs_q[i_wr_addr] <= i_wr_data;  // Writes to r0 dropped
    end
  end

endmodule

//--- mips_core.f
+incdir+include
logic/mips_pkg.sv
logic/cpu_ctl.sv
logic/mips_alu.sv
logic/mips_regfile.sv
logic/mips_data_mem.sv
logic/mips_core.sv
sim/mips_core_asserts.sv
sim/mips_core_tb.sv

//--- sim/mips_core_asserts.sv
// --------------------------------------------------
// Decoder checks on the core's cpu_ctl instance.
// Decode rules restated from the instruction set.
// --------------------------------------------------
`timescale 1ns/1ns

module mips_ctl_checks (
  input logic              i_clk,
  input logic              i_rst_n,
  input mips_pkg::instr_u  i_instr,
  input logic              i_equal,
  input mips_pkg::ctl_s    i_ctl
);
  import mips_pkg::*;

  logic [5:0] op;
  logic [5:0] fn;
  logic       is_r;
  logic       is_jmp;
  logic       is_br;
  logic       is_alui;
  logic       is_mem;
  logic       is_other;
  logic       exp_wreg;
  logic       exp_sext;

  assign op       = i_instr.i_fmt.op;
  assign fn       = i_instr.r_fmt.funct;
  assign is_r     = (op == 6'h00);
  assign is_jmp   = (op == 6'h02) || (op == 6'h03);
  assign is_br    = (op == 6'h04) || (op == 6'h05);
  assign is_alui  = (op[5:3] == 3'b001);  // addi through lui
  assign is_mem   = (op == 6'h23) || (op == 6'h2b);
  assign is_other = !(is_r || is_jmp || is_br || is_alui || is_mem);

  assign exp_wreg = (is_r && (fn inside {6'h20, 6'h21, 6'h22, 6'h24, 6'h25, 6'h26,
                                         6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03}))
                    || (op == 6'h03) || is_alui || (op == 6'h23);
  assign exp_sext = (op inside {6'h08, 6'h09, 6'h0a, 6'h0b}) || is_mem || is_br;

  // Decoded classes: R-type ALU, immediate, jump, branch
  a_class: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $onehot0({i_ctl.rd_dest, i_ctl.imm_src, i_ctl.j || i_ctl.jal || i_ctl.jr,
              i_ctl.take_branch}))
    else $error("decode falls in more than one opcode class");
  a_noop: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    is_other |-> !(i_ctl.wreg || i_ctl.wmem || i_ctl.j || i_ctl.jal || i_ctl.jr))
    else $error("unsupported opcode writes or jumps");
  a_flags: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $onehot0({i_ctl.jr, i_ctl.j, i_ctl.jal, i_ctl.lw, i_ctl.wmem, i_ctl.take_branch}))
    else $error("more than one exclusive control flag set");
  a_rd_dest: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_ctl.rd_dest |-> (is_r && fn != 6'h08)) else $error("rd_dest outside R-type ALU ops");
  a_wmem: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_ctl.wmem |-> !i_ctl.wreg) else $error("store also writes a register");
  a_branch: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_ctl.take_branch == (is_br && ((op == 6'h04) == i_equal)))
    else $error("branch decision disagrees with opcode and compare");
  a_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !$isunknown(i_ctl)) else $error("control output unknown");
  a_wreg: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_ctl.wreg == exp_wreg) else $error("register write enable disagrees with opcode");
  a_sext: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_ctl.sext == exp_sext) else $error("immediate extension disagrees with opcode");
  a_lui: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (op == 6'h0f) |-> (i_ctl.alu_op == LUI)) else $error("lui not decoded to LUI");
  a_sub: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (is_r && fn == 6'h22) |-> (i_ctl.alu_op == SUB)) else $error("sub not decoded to SUB");

endmodule

bind mips_core mips_ctl_checks ctl_checks_i (
  .i_clk   (i_clk),
  .i_rst_n (i_rst_n),
  .i_instr (instr),
  .i_equal (equal),
  .i_ctl   (ctl)
);

//--- sim/mips_core_tb.sv
// --------------------------------------------------
// Streams instructions into the core and checks each
// result record against a model, under back-pressure.
// --------------------------------------------------
`timescale 1ns/1ns
`include "mips_cfg.svh"

module mips_core_tb;
  import mips_pkg::*;

  localparam int N_INSTR     = 64 + 96 + 48 + 11 + 8 + 40;  // Summed per-test counts
  localparam int CYCLE_LIMIT = 2 * N_INSTR + 200;
  localparam int EXP_DEPTH   = 512;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [31:0] instr;
  logic        instr_valid;
  logic        instr_ready;
  result_s     res;
  logic        res_valid;
  logic        res_ready;
  logic        bp_en;
  logic [15:0] stim_lfsr;
  logic [15:0] bp_lfsr;
  logic [31:0] bp_bits;
  logic [31:0] m_regs [`MIPS_NUM_REGS];
  logic [31:0] m_mem [`MIPS_DMEM_WORDS];
  logic [31:0] m_pc;
  result_s     exp_mem [EXP_DEPTH];
  result_s     exp_head;
  int          wr_idx;
  int          rd_idx;
  int          errors = 0;
  int          cycles = 0;
  int          tests_done;

  mips_core dut_i (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_instr       (instr),
    .i_instr_valid (instr_valid),
    .o_instr_ready (instr_ready),
    .o_res         (res),
    .o_res_valid   (res_valid),
    .i_res_ready   (res_ready)
  );

  always #50 clk = ~clk;

  // Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] take_bits(inout logic [15:0] st, input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = st[15] ^ st[13] ^ st[12] ^ st[10];
      st = {st[14:0], fb};
      v  = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] enc_r(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                        logic [4:0] rd, logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                        logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // Reference model, one instruction
  task automatic model_exec(input logic [31:0] w);
    instr_u      u;
    result_s     e;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] se;
    logic [31:0] ze;
    logic [31:0] pc4;
    logic [31:0] addr;
    logic [31:0] wd;
    logic [4:0]  wa;
    logic        wr;
    int          idx;
    u    = w;
    a    = m_regs[u.i_fmt.rs];
    b    = m_regs[u.i_fmt.rt];
    se   = {{16{u.i_fmt.imm[15]}}, u.i_fmt.imm};
    ze   = {16'h0000, u.i_fmt.imm};
    pc4  = m_pc + 32'd4;
    addr = a + se;
    idx  = int'((addr >> 2) % `MIPS_DMEM_WORDS);
    e    = '0;
    e.pc = m_pc;
    e.next_pc = pc4;
    wr = 1'b1;
    wa = u.i_fmt.rt;
    wd = '0;
    case (u.i_fmt.op)
      6'h00: begin
        wa = u.r_fmt.rd;
        case (u.r_fmt.funct)
          6'h20, 6'h21: wd = a + b;
          6'h22: wd = a - b;
          6'h24: wd = a & b;
          6'h25: wd = a | b;
          6'h26: wd = a ^ b;
          6'h2a: wd = {31'd0, $signed(a) < $signed(b)};
          6'h2b: wd = {31'd0, a < b};
          6'h00: wd = b << u.r_fmt.shamt;
          6'h02: wd = b >> u.r_fmt.shamt;
          6'h03: wd = $signed(b) >>> u.r_fmt.shamt;
          6'h08: begin
            wr = 1'b0;
            e.next_pc = a;
          end
          default: wr = 1'b0;
        endcase
      end
      6'h02: begin
        wr = 1'b0;
        e.next_pc = {pc4[31:28], u.j_fmt.target, 2'b00};
      end
      6'h03: begin
        e.next_pc = {pc4[31:28], u.j_fmt.target, 2'b00};
        wa = 5'd31;
        wd = pc4;  // Link
      end
      6'h04, 6'h05: begin
        wr = 1'b0;
        if ((a == b) == (u.i_fmt.op == 6'h04)) e.next_pc = pc4 + {se[29:0], 2'b00};
      end
      6'h08, 6'h09: wd = a + se;
      6'h0a: wd = {31'd0, $signed(a) < $signed(se)};
      6'h0b: wd = {31'd0, a < se};
      6'h0c: wd = a & ze;
      6'h0d: wd = a | ze;
      6'h0e: wd = a ^ ze;
      6'h0f: wd = {u.i_fmt.imm, 16'h0000};
      6'h23: wd = m_mem[idx];
      6'h2b: begin
        wr = 1'b0;
        e.wmem     = 1'b1;
        e.mem_addr = addr;
        e.mem_data = b;
        m_mem[idx] = b;
      end
      default: wr = 1'b0;  // No-op
    endcase
    if (wr) begin
      e.wreg    = 1'b1;
      e.wr_addr = wa;
      e.wr_data = wd;
      if (wa != 5'd0) m_regs[wa] = wd;
    end
    m_pc = e.next_pc;
    exp_mem[wr_idx % EXP_DEPTH] = e;
    wr_idx++;
  endtask

  // Hold valid until the core takes the word
  task automatic issue(input logic [31:0] w);
    logic acc;
    model_exec(w);
    instr       = w;
    instr_valid = 1'b1;
    acc         = 1'b0;
    while (!acc) begin
      @(negedge clk);
      acc = instr_ready;
      @(posedge clk);
    end
    #5;
    instr_valid = 1'b0;
  endtask

  task automatic end_test(input string name);
    while (rd_idx != wr_idx) begin
      @(posedge clk);
      #5;
    end
    tests_done++;
    $display("test %s done, %0d results so far, %0d errors", name, rd_idx, errors);
  endtask

  always @(posedge clk) begin
    if (!rst_n) rd_idx <= 0;
    else if (res_valid && res_ready) rd_idx <= rd_idx + 1;
  end

  always @(posedge clk) begin
    #5;
    if (bp_en) begin
      bp_bits   = take_bits(bp_lfsr, 1);
      res_ready = bp_bits[0];
    end else begin
      res_ready = 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles with %0d results missing", cycles, wr_idx - rd_idx);
      $display("Errors found");
      $finish;
    end
  end

  assign exp_head = exp_mem[rd_idx % EXP_DEPTH];

  a_pc: assert property (@(posedge clk) disable iff (!rst_n)
    (res_valid && res_ready) |-> res.pc == exp_head.pc)
    else begin
      errors++;
      $display("mismatch pc: got %h expected %h", $sampled(res.pc), $sampled(exp_head.pc));
    end
  a_next_pc: assert property (@(posedge clk) disable iff (!rst_n)
    (res_valid && res_ready) |-> res.next_pc == exp_head.next_pc)
    else begin
      errors++;
      $display("mismatch next_pc: got %h expected %h", $sampled(res.next_pc),
               $sampled(exp_head.next_pc));
    end
  a_wreg: assert property (@(posedge clk) disable iff (!rst_n)
    (res_valid && res_ready) |-> res.wreg == exp_head.wreg)
    else begin
      errors++;
      $display("mismatch wreg: got %h expected %h", $sampled(res.wreg),
               $sampled(exp_head.wreg));
    end
  a_wr_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (res_valid && res_ready) |-> res.wr_addr == exp_head.wr_addr)
    else begin
      errors++;
      $display("mismatch wr_addr: got %h expected %h", $sampled(res.wr_addr),
               $sampled(exp_head.wr_addr));
    end
  a_wr_data: assert property (@(posedge clk) disable iff (!rst_n)
    (res_valid && res_ready) |-> res.wr_data == exp_head.wr_data)
    else begin
      errors++;
      $display("mismatch wr_data: got %h expected %h", $sampled(res.wr_data),
               $sampled(exp_head.wr_data));
    end
  a_wmem: assert property (@(posedge clk) disable iff (!rst_n)
    (res_valid && res_ready) |-> res.wmem == exp_head.wmem)
    else begin
      errors++;
      $display("mismatch wmem: got %h expected %h", $sampled(res.wmem),
               $sampled(exp_head.wmem));
    end
  a_mem_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (res_valid && res_ready) |-> res.mem_addr == exp_head.mem_addr)
    else begin
      errors++;
      $display("mismatch mem_addr: got %h expected %h", $sampled(res.mem_addr),
               $sampled(exp_head.mem_addr));
    end
  a_mem_data: assert property (@(posedge clk) disable iff (!rst_n)
    (res_valid && res_ready) |-> res.mem_data == exp_head.mem_data)
    else begin
      errors++;
      $display("mismatch mem_data: got %h expected %h", $sampled(res.mem_data),
               $sampled(exp_head.mem_data));
    end
  a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
    (res_valid && res_ready) |-> rd_idx < wr_idx)
    else begin
      errors++;
      $display("result delivered with no instruction outstanding");
    end
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (res_valid && !res_ready) |=> (res_valid && $stable(res)))
    else begin
      errors++;
      $display("result dropped or changed while stalled");
    end

  initial begin
    logic [31:0] t;
    logic [31:0] t2;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;
    logic [15:0] bases [8];
    logic [15:0] offs [8];
    logic [5:0]  fns [11];
    fns = '{6'h20, 6'h21, 6'h22, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03};
    rst_n       = 1'b0;
    instr       = '0;
    instr_valid = 1'b0;
    res_ready   = 1'b1;
    bp_en       = 1'b0;
    stim_lfsr   = 16'd33;
    bp_lfsr     = 16'd33;
    wr_idx      = 0;
    tests_done  = 0;
    m_pc        = `MIPS_RESET_PC;
    for (int i = 0; i < `MIPS_NUM_REGS; i++) m_regs[i] = '0;
    for (int i = 0; i < `MIPS_DMEM_WORDS; i++) m_mem[i] = '0;
    repeat (2) @(posedge clk);
    #5;
    rst_n = 1'b1;

    // Immediate ops, imm sign bit alternates
    for (int k = 0; k < 8; k++) begin
      rd = 5'd1 + {3'd0, k[1:0]};
      t  = take_bits(stim_lfsr, 32);
      issue(enc_i(6'h0f, 5'd0, rd, t[31:16]));
      issue(enc_i(6'h0d, rd, rd, t[15:0]));
      t   = take_bits(stim_lfsr, 15);
      imm = {k[0], t[14:0]};
      issue(enc_i(6'h08, rd, 5'd5, imm));
      issue(enc_i(6'h09, rd, 5'd6, imm));
      issue(enc_i(6'h0c, rd, 5'd7, imm));
      issue(enc_i(6'h0e, rd, 5'd8, imm));
      issue(enc_i(6'h0a, rd, 5'd9, imm));
      issue(enc_i(6'h0b, rd, 5'd10, imm));
    end
    end_test("imm");

    // R-type, one write to r0 per round then a read of r0
    for (int k = 0; k < 8; k++) begin
      for (int j = 0; j < 11; j++) begin
        t  = take_bits(stim_lfsr, 16);
        rs = 5'd1 + {2'd0, t[2:0]};
        rt = 5'd1 + {2'd0, t[5:3]};
        rd = (j == k) ? 5'd0 : t[15:11];
        issue(enc_r(fns[j], rs, rt, rd, t[10:6]));
      end
      issue(enc_r(6'h20, 5'd0, rs, 5'd11, 5'd0));
    end
    end_test("rtype");

    // Stores then loads of the same addresses
    for (int k = 0; k < 8; k++) begin
      t  = take_bits(stim_lfsr, 32);
      t2 = take_bits(stim_lfsr, 32);
      bases[k] = t2[31:16];
      offs[k]  = t2[15:0];
      issue(enc_i(6'h0f, 5'd0, 5'd10, t[31:16]));
      issue(enc_i(6'h0d, 5'd10, 5'd10, t[15:0]));
      issue(enc_i(6'h08, 5'd0, 5'd11, bases[k]));
      issue(enc_i(6'h2b, 5'd11, 5'd10, offs[k]));
    end
    for (int k = 0; k < 8; k++) begin
      issue(enc_i(6'h08, 5'd0, 5'd11, bases[k]));
      issue(enc_i(6'h23, 5'd11, 5'd12, offs[k]));
    end
    end_test("mem");

    issue(enc_i(6'h08, 5'd0, 5'd1, 16'd5));
    issue(enc_i(6'h08, 5'd0, 5'd2, 16'd5));
    issue(enc_i(6'h08, 5'd0, 5'd3, 16'd7));
    for (int k = 0; k < 2; k++) begin
      imm = (k == 0) ? 16'h0010 : 16'hfff0;  // Forward, then backward
      issue(enc_i(6'h04, 5'd1, 5'd2, imm));
      issue(enc_i(6'h04, 5'd1, 5'd3, imm));
      issue(enc_i(6'h05, 5'd1, 5'd3, imm));
      issue(enc_i(6'h05, 5'd1, 5'd2, imm));
    end
    end_test("branch");

    t  = take_bits(stim_lfsr, 26);
    t2 = take_bits(stim_lfsr, 26);
    issue({6'h02, t[25:0]});
    issue({6'h03, t2[25:0]});
    issue(enc_r(6'h08, 5'd31, 5'd0, 5'd0, 5'd0));
    issue(enc_i(6'h08, 5'd0, 5'd4, 16'h0400));
    issue(enc_r(6'h08, 5'd4, 5'd0, 5'd0, 5'd0));
    issue(32'hfc22_1234);                             // Unknown opcode
    issue(enc_r(6'h3f, 5'd1, 5'd2, 5'd3, 5'd0));      // Unknown funct
    issue(enc_i(6'h10, 5'd1, 5'd2, 16'h5555));
    end_test("jump");

    // Mixed stream with random stalls on the result side
    bp_en = 1'b1;
    for (int k = 0; k < 40; k++) begin
      t  = take_bits(stim_lfsr, 32);
      rs = 5'd1 + {2'd0, t[5:3]};
      rt = 5'd1 + {2'd0, t[8:6]};
      case (t[2:0])
        3'd0: issue(enc_i(6'h08, rs, rt, t[31:16]));
        3'd1: issue(enc_r(6'h20, rs, rt, 5'd13, 5'd0));
        3'd2: issue(enc_i(6'h2b, rs, rt, t[31:16]));
        3'd3: issue(enc_i(6'h23, rs, rt, t[31:16]));
        3'd4: issue(enc_i(6'h04, rs, rt, t[31:16]));
        3'd5: issue(enc_r(6'h03, 5'd0, rt, 5'd14, t[13:9]));
        3'd6: issue({6'h03, t[31:6]});
        default: issue(enc_i(6'h0b, rs, rt, t[31:16]));
      endcase
    end
    end_test("backpres");
    bp_en = 1'b0;

    $display("summary: %0d tests, %0d sent, %0d received, %0d errors",
             tests_done, wr_idx, rd_idx, errors);
    if (errors == 0 && rd_idx == wr_idx) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
